// ==== project.f ====
hw/usiPkg.sv
hw/axilUsiBridge.sv
hw/usiAddressDecoder.sv
hw/pwmBlock.sv
hw/usiReadCollector.sv
hw/pwmSubsystem.sv
bench/pwmSubsystem_asserts.sv
bench/pwmSubsystemTb.sv

// ==== Makefile ====
# Verilator simulation of the PWM subsystem testbench

VERILATOR ?= verilator
TOP ?= pwmSubsystemTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/pwmSubsystemTb.sv ====
// Testbench with clock, reset, AXI4-Lite driver tasks, value checks, PWM measurement, watchdog
`timescale 1ns/1ps
`default_nettype none

module pwmSubsystemTb;

	localparam int numChannels = 4;
	localparam int resetCycles = 16;
	// Random periods stay short so frames are quick to measure
	localparam int maxPeriod = 40;
	localparam int stressCount = 40;
	// Handshake, pipeline and stall slack of one transfer
	localparam int transferCycles = 30;
	// Readback, unmapped, duty, isolation and stall transfers
	localparam int transferCount = numChannels * 7 + 5 + numChannels * 3
		+ 4 + numChannels * 3 + stressCount;
	// Settle and two frames per channel plus the disabled window
	localparam int pwmCycles = numChannels * 3 * (maxPeriod + 3) + 3 * (maxPeriod + 1);
	localparam int watchdogCycles = resetCycles + transferCount * transferCycles
		+ pwmCycles + 500;

	logic sysClk;
	logic rstN;
	logic awvalid;
	logic awready;
	usiPkg::usiAddr_t awaddr;
	logic wvalid;
	logic wready;
	usiPkg::usiData_t wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	usiPkg::axiResp_t bresp;
	logic arvalid;
	logic arready;
	usiPkg::usiAddr_t araddr;
	logic rvalid;
	logic rready;
	usiPkg::usiData_t rdata;
	usiPkg::axiResp_t rresp;
	logic [numChannels-1:0] pwm;

	int errorCount;
	int unsigned protocolErrors;
	// Random ready stalls on B and R
	bit stallOn;
	// Register model per channel
	logic expEnable [numChannels];
	usiPkg::pwmCount_t expPeriod [numChannels];
	usiPkg::pwmCount_t expDuty [numChannels];

	pwmSubsystem #(
		.numChannels(numChannels)
	) i_pwmSubsystem (
		.sysClk(sysClk),
		.rstN(rstN),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.pwm(pwm)
	);

	// 4 ns period
	initial sysClk = 1'b0;
	always #2 sysClk = ~sysClk;

	// ----------------------------------------
	// Checks and model
	// ----------------------------------------
	task automatic checkValue(input string name, input usiPkg::usiData_t expected,
		input usiPkg::usiData_t actual);
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkNotAbove(input string name, input usiPkg::usiData_t limit,
		input usiPkg::usiData_t actual);
		assert (actual <= limit)
		else
		begin
			errorCount++;
			$display("mismatch %s: expected at most %h, actual %h", name, limit, actual);
		end
	endtask

	// Block counted from channel 0 and possibly outside the map
	function automatic usiPkg::usiAddr_t regAddr(input int block,
		input usiPkg::regOffset_t offset);
		usiPkg::blockId_t id;
		id = usiPkg::blockId_t'(int'(usiPkg::pwmBlockBase) + block);
		return {id, offset};
	endfunction

	function automatic usiPkg::usiData_t expectedReg(input int ch,
		input usiPkg::regOffset_t offset);
		case (offset)
			usiPkg::regCtrl:
				return usiPkg::usiData_t'(expEnable[ch]);
			usiPkg::regPeriod:
				return usiPkg::usiData_t'(expPeriod[ch]);
			usiPkg::regDuty:
				return usiPkg::usiData_t'(expDuty[ch]);
			default:
				return '0;
		endcase
	endfunction

	function automatic logic readyBit();
		return stallOn ? (($urandom % 2) == 0) : 1'b1;
	endfunction

	// ----------------------------------------
	// AXI4-Lite driver
	// ----------------------------------------
	// Called right after a rising edge
	task automatic axiWrite(input usiPkg::usiAddr_t addr, input usiPkg::usiData_t data,
		output usiPkg::axiResp_t resp);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		wstrb <= '1;
		@(posedge sysClk);
		while (!awready)
			@(posedge sysClk);
		// AW and W are taken in the same cycle
		checkValue("write data ready", 1, wready);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= readyBit();
		@(posedge sysClk);
		while (!(bvalid && bready))
		begin
			bready <= readyBit();
			@(posedge sysClk);
		end
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axiRead(input usiPkg::usiAddr_t addr, output usiPkg::usiData_t data,
		output usiPkg::axiResp_t resp);
		arvalid <= 1'b1;
		araddr <= addr;
		@(posedge sysClk);
		while (!arready)
			@(posedge sysClk);
		arvalid <= 1'b0;
		rready <= readyBit();
		@(posedge sysClk);
		while (!(rvalid && rready))
		begin
			rready <= readyBit();
			@(posedge sysClk);
		end
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	// Write a mapped register and track it in the model
	task automatic writeReg(input string name, input int ch, input usiPkg::regOffset_t offset,
		input usiPkg::usiData_t value);
		usiPkg::axiResp_t resp;
		axiWrite(regAddr(ch, offset), value, resp);
		checkValue({name, " bresp"}, usiPkg::respOkay, resp);
		case (offset)
			usiPkg::regCtrl:
				expEnable[ch] = value[0];
			usiPkg::regPeriod:
				expPeriod[ch] = value[15:0];
			usiPkg::regDuty:
				expDuty[ch] = value[15:0];
			default:
			begin
			end
		endcase
	endtask

	task automatic readCompare(input string name, input int ch,
		input usiPkg::regOffset_t offset);
		usiPkg::usiData_t data;
		usiPkg::axiResp_t resp;
		axiRead(regAddr(ch, offset), data, resp);
		checkValue($sformatf("%s ch%0d reg%0h", name, ch, offset), expectedReg(ch, offset), data);
		checkValue({name, " rresp"}, usiPkg::respOkay, resp);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic registerReadback();
		int period;
		usiPkg::usiData_t data;
		usiPkg::axiResp_t resp;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			period = $urandom_range(maxPeriod, 1);
			writeReg("readback", ch, usiPkg::regPeriod, period);
			writeReg("readback", ch, usiPkg::regDuty, $urandom_range(period + 1, 0));
			writeReg("readback", ch, usiPkg::regCtrl, $urandom_range(1, 0));
		end
		for (int ch = 0; ch < numChannels; ch++)
		begin
			readCompare("readback", ch, usiPkg::regCtrl);
			readCompare("readback", ch, usiPkg::regPeriod);
			readCompare("readback", ch, usiPkg::regDuty);
			// Counter never runs past period
			axiRead(regAddr(ch, usiPkg::regCount), data, resp);
			checkNotAbove("readback count", expPeriod[ch], data);
			checkValue("readback count rresp", usiPkg::respOkay, resp);
		end
	endtask

	task automatic unmappedAccess();
		int block;
		usiPkg::usiData_t data;
		usiPkg::axiResp_t resp;
		// Just below channel 0 and just past the last channel
		for (int i = 0; i < 2; i++)
		begin
			block = (i == 0) ? -1 : numChannels;
			axiWrite(regAddr(block, usiPkg::regPeriod), $urandom, resp);
			checkValue("unmapped bresp", usiPkg::respDecErr, resp);
			axiRead(regAddr(block, usiPkg::regPeriod), data, resp);
			checkValue("unmapped rresp", usiPkg::respDecErr, resp);
			checkValue("unmapped rdata", '0, data);
		end
		// Hole inside a mapped block
		axiRead(regAddr(0, 8'h10), data, resp);
		checkValue("unknown offset rdata", '0, data);
		checkValue("unknown offset rresp", usiPkg::respOkay, resp);
	endtask

	task automatic dutyCycle();
		int period;
		int duty;
		int frame;
		int highCount;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			period = $urandom_range(maxPeriod, 1);
			duty = $urandom_range(period + 1, 0);
			frame = period + 1;
			writeReg("duty", ch, usiPkg::regPeriod, period);
			writeReg("duty", ch, usiPkg::regDuty, duty);
			writeReg("duty", ch, usiPkg::regCtrl, 1);
			// Let the counter wrap into the new frame
			repeat (frame + 2)
				@(posedge sysClk);
			highCount = 0;
			// Two whole frames at any alignment
			repeat (2 * frame)
			begin
				@(posedge sysClk);
				if (pwm[ch])
					highCount++;
			end
			checkValue($sformatf("duty ch%0d high cycles", ch), 2 * duty, highCount);
		end
	endtask

	task automatic disableIsolation();
		int highCount;
		// Full duty so an enabled channel would be high every cycle
		writeReg("disable", 1, usiPkg::regDuty, expPeriod[1] + 1);
		writeReg("disable", 1, usiPkg::regCtrl, 0);
		highCount = 0;
		repeat (3 * (maxPeriod + 1))
		begin
			@(posedge sysClk);
			if (pwm[1])
				highCount++;
		end
		checkValue("disabled pwm high cycles", 0, highCount);
		// Other channels keep their registers
		writeReg("isolation", 2, usiPkg::regPeriod, $urandom_range(maxPeriod, 1));
		writeReg("isolation", 2, usiPkg::regDuty, $urandom_range(maxPeriod + 1, 0));
		for (int ch = 0; ch < numChannels; ch++)
		begin
			readCompare("isolation", ch, usiPkg::regCtrl);
			readCompare("isolation", ch, usiPkg::regPeriod);
			readCompare("isolation", ch, usiPkg::regDuty);
		end
	endtask

	task automatic backPressure();
		int ch;
		usiPkg::regOffset_t offset;
		stallOn = 1'b1;
		for (int i = 0; i < stressCount; i++)
		begin
			ch = $urandom_range(numChannels - 1, 0);
			case ($urandom_range(2, 0))
				0:
					offset = usiPkg::regCtrl;
				1:
					offset = usiPkg::regPeriod;
				default:
					offset = usiPkg::regDuty;
			endcase
			if ($urandom_range(1, 0) == 1)
				writeReg("stall", ch, offset, (offset == usiPkg::regCtrl) ?
					$urandom_range(1, 0) : $urandom_range(maxPeriod, 1));
			else
				readCompare("stall", ch, offset);
		end
		stallOn = 1'b0;
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		void'($urandom(32'h3e543759));
		rstN = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		errorCount = 0;
		stallOn = 1'b0;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			expEnable[ch] = 1'b0;
			expPeriod[ch] = '0;
			expDuty[ch] = '0;
		end
		repeat (resetCycles)
			@(posedge sysClk);
		rstN <= 1'b1;
		repeat (2)
			@(posedge sysClk);
		registerReadback();
		unmappedAccess();
		dutyCycle();
		disableIsolation();
		backPressure();
		// Let pending assertions finish
		repeat (8)
			@(posedge sysClk);
		protocolErrors = i_pwmSubsystem.i_asserts.failCount;
		$display("summary: %0d value errors, %0d assertion errors", errorCount, protocolErrors);
		if (errorCount == 0 && protocolErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog sized from the test lengths
	initial
	begin
		repeat (watchdogCycles)
			@(posedge sysClk);
		$display("timeout: tests did not finish within %0d cycles", watchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/pwmSubsystem_asserts.sv ====
// Bound AXI4-Lite handshake, reset and response latency assertions for the PWM subsystem
`timescale 1ns/1ps
`default_nettype none

module pwmSubsystemAsserts (
	input wire logic sysClk,
	input wire logic rstN,
	input wire logic awvalid,
	input wire logic awready,
	input wire logic wvalid,
	input wire logic bvalid,
	input wire logic bready,
	input wire usiPkg::axiResp_t bresp,
	input wire logic arvalid,
	input wire logic arready,
	input wire logic rvalid,
	input wire logic rready,
	input wire usiPkg::usiData_t rdata,
	input wire usiPkg::axiResp_t rresp
);

	// Count of failed assertions
	int unsigned failCount = 0;

	// ----------------------------------------
	// Valid holds until ready
	// ----------------------------------------
	// Responses held with stable payload under back-pressure
	writeRespHold: assert property (@(posedge sysClk) disable iff (!rstN)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		failCount++;
		$error("write response dropped or changed before bready");
	end

	readRespHold: assert property (@(posedge sysClk) disable iff (!rstN)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		failCount++;
		$error("read response dropped or changed before rready");
	end

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	// Covers the reset cycles and the first one after release
	quietAfterReset: assert property (@(posedge sysClk)
		!rstN |=> !(awvalid || wvalid || arvalid || bvalid || rvalid))
	else
	begin
		failCount++;
		$error("valid raised during reset or in the first cycle after it");
	end

	// ----------------------------------------
	// Latency
	// ----------------------------------------
	// Request, sel, ack and done come before the response
	writeLatency: assert property (@(posedge sysClk) disable iff (!rstN)
		awvalid && awready |=> ##4 $rose(bvalid))
	else
	begin
		failCount++;
		$error("write response not raised 4 cycles after the request");
	end

	readLatency: assert property (@(posedge sysClk) disable iff (!rstN)
		arvalid && arready |=> ##4 $rose(rvalid))
	else
	begin
		failCount++;
		$error("read response not raised 4 cycles after the request");
	end

endmodule

bind pwmSubsystem pwmSubsystemAsserts i_asserts (.*);

`default_nettype wire

// ==== hw/pwmSubsystem.sv ====
// PWM subsystem top with bridge, decoder, generated PWM blocks and read collector
`timescale 1ns/1ps
`default_nettype none

module pwmSubsystem #(
	// Number of PWM channels, 1 to 8
	parameter int numChannels = 4
) (
	input wire logic sysClk,
	input wire logic rstN,
	// AXI4-Lite slave
	input wire logic awvalid,
	output logic awready,
	input wire usiPkg::usiAddr_t awaddr,
	input wire logic wvalid,
	output logic wready,
	input wire usiPkg::usiData_t wdata,
	input wire logic [$bits(usiPkg::usiData_t)/8-1:0] wstrb,
	output logic bvalid,
	input wire logic bready,
	output usiPkg::axiResp_t bresp,
	input wire logic arvalid,
	output logic arready,
	input wire usiPkg::usiAddr_t araddr,
	output logic rvalid,
	input wire logic rready,
	output usiPkg::usiData_t rdata,
	output usiPkg::axiResp_t rresp,
	// One pin per channel
	output logic [numChannels-1:0] pwm
);

	localparam int dataBits = $bits(usiPkg::usiData_t);

	// Bridge to decoder
	logic reqValid;
	logic reqWrite;
	usiPkg::usiAddr_t reqAddr;
	usiPkg::usiData_t reqData;
	// Decoder to blocks and collector
	logic [numChannels-1:0] sel;
	logic busWrite;
	usiPkg::regOffset_t busOffset;
	usiPkg::usiData_t busData;
	logic miss;
	// Blocks to collector
	logic [numChannels-1:0] ack;
	logic [numChannels*dataBits-1:0] rdData;
	// Collector to bridge
	logic doneValid;
	usiPkg::usiData_t doneData;
	usiPkg::axiResp_t doneResp;

	// ----------------------------------------
	// AXI4-Lite bridge
	// ----------------------------------------
	axilUsiBridge i_bridge (
		.sysClk(sysClk),
		.rstN(rstN),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.doneValid(doneValid),
		.doneData(doneData),
		.doneResp(doneResp)
	);

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	usiAddressDecoder #(
		.numChannels(numChannels)
	) i_decoder (
		.sysClk(sysClk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.sel(sel),
		.busWrite(busWrite),
		.busOffset(busOffset),
		.busData(busData),
		.miss(miss)
	);

	// ----------------------------------------
	// PWM channels
	// ----------------------------------------
	// Channel i answers at block pwmBlockBase plus i
	for (genvar i = 0; i < numChannels; i++)
	begin : gChannel
		pwmBlock i_pwmBlock (
			.sysClk(sysClk),
			.rstN(rstN),
			.sel(sel[i]),
			.busWrite(busWrite),
			.busOffset(busOffset),
			.busData(busData),
			.ack(ack[i]),
			.rdData(rdData[i*dataBits +: dataBits]),
			.pwm(pwm[i])
		);
	end

	// ----------------------------------------
	// Response merge
	// ----------------------------------------
	usiReadCollector #(
		.numChannels(numChannels)
	) i_collector (
		.sysClk(sysClk),
		.rstN(rstN),
		.ack(ack),
		.rdData(rdData),
		.miss(miss),
		.doneValid(doneValid),
		.doneData(doneData),
		.doneResp(doneResp)
	);

endmodule

`default_nettype wire

// ==== hw/usiReadCollector.sv ====
// Read collector merging block acknowledges and data, or a miss, into one response
`timescale 1ns/1ps
`default_nettype none

module usiReadCollector #(
	// Number of PWM blocks, 1 to 8
	parameter int numChannels = 4
) (
	input wire logic sysClk,
	input wire logic rstN,
	input wire logic [numChannels-1:0] ack,
	input wire logic [numChannels*$bits(usiPkg::usiData_t)-1:0] rdData,
	input wire logic miss,
	output logic doneValid,
	output usiPkg::usiData_t doneData,
	output usiPkg::axiResp_t doneResp
);

	localparam int dataBits = $bits(usiPkg::usiData_t);

	usiPkg::usiData_t ackData;
	// Miss delayed one cycle to line up with a block acknowledge
	logic missQ;

	// AND-OR mux over the one acknowledging block
	always_comb
	begin
		ackData = '0;
		for (int i = 0; i < numChannels; i++)
			if (ack[i])
				ackData = ackData | rdData[i*dataBits +: dataBits];
	end

	// ----------------------------------------
	// Response stage
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			missQ <= 1'b0;
			doneValid <= 1'b0;
		end
		else
		begin
			missQ <= miss;
			doneValid <= (|ack) || missQ;
		end
	end

	// Miss answers with zero data and DECERR
	always_ff @(posedge sysClk)
	begin
		doneData <= missQ ? '0 : ackData;
		doneResp <= missQ ? usiPkg::respDecErr : usiPkg::respOkay;
	end

endmodule

`default_nettype wire

// ==== hw/pwmBlock.sv ====
// PWM channel with enable, period and duty registers, counter and output pin
`timescale 1ns/1ps
`default_nettype none

module pwmBlock (
	input wire logic sysClk,
	input wire logic rstN,
	// Bus side
	input wire logic sel,
	input wire logic busWrite,
	input wire usiPkg::regOffset_t busOffset,
	input wire usiPkg::usiData_t busData,
	output logic ack,
	output usiPkg::usiData_t rdData,
	// Pin
	output logic pwm
);

	logic enable;
	usiPkg::pwmCount_t period;
	usiPkg::pwmCount_t duty;
	usiPkg::pwmCount_t counter;
	usiPkg::usiData_t readMux;

	// ----------------------------------------
	// Register file
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			enable <= 1'b0;
			period <= '0;
			duty <= '0;
		end
		else if (sel && busWrite)
		begin
			case (busOffset)
				usiPkg::regCtrl:
					enable <= busData[0];
				usiPkg::regPeriod:
					period <= busData[$bits(usiPkg::pwmCount_t)-1:0];
				usiPkg::regDuty:
					duty <= busData[$bits(usiPkg::pwmCount_t)-1:0];
				// Counter and unknown offsets ignore writes
				default:
				begin
				end
			endcase
		end
	end

	// Readback, zero for anything not mapped
	always_comb
	begin
		case (busOffset)
			usiPkg::regCtrl:
				readMux = {{($bits(usiPkg::usiData_t)-1){1'b0}}, enable};
			usiPkg::regPeriod:
				readMux = usiPkg::usiData_t'(period);
			usiPkg::regDuty:
				readMux = usiPkg::usiData_t'(duty);
			usiPkg::regCount:
				readMux = usiPkg::usiData_t'(counter);
			default:
				readMux = '0;
		endcase
	end

	// Acknowledge one cycle after the strobe, reads and writes alike
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			ack <= 1'b0;
		else
			ack <= sel;
	end

	always_ff @(posedge sysClk)
	begin
		if (sel)
			rdData <= readMux;
	end

	// ----------------------------------------
	// Counter and output
	// ----------------------------------------
	// Frame is period plus one cycles
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			counter <= '0;
			pwm <= 1'b0;
		end
		else
		begin
			if (!enable)
				counter <= '0;
			else if (counter >= period)
				counter <= '0;
			else
				counter <= counter + 1'b1;
			// High for duty cycles of every frame
			pwm <= enable && (counter < duty);
		end
	end

endmodule

`default_nettype wire

// ==== hw/usiAddressDecoder.sv ====
// Address decoder from bus request to registered block strobes or a miss pulse
`timescale 1ns/1ps
`default_nettype none

module usiAddressDecoder #(
	// Number of PWM blocks, 1 to 8
	parameter int numChannels = 4
) (
	input wire logic sysClk,
	input wire logic rstN,
	input wire logic reqValid,
	input wire logic reqWrite,
	input wire usiPkg::usiAddr_t reqAddr,
	input wire usiPkg::usiData_t reqData,
	output logic [numChannels-1:0] sel,
	output logic busWrite,
	output usiPkg::regOffset_t busOffset,
	output usiPkg::usiData_t busData,
	output logic miss
);

	usiPkg::blockId_t blkIndex;
	logic inMap;
	logic [numChannels-1:0] selNext;

	// Block number relative to channel 0, wraps below the base
	assign blkIndex = usiPkg::blockId_t'(reqAddr[15:8] - usiPkg::pwmBlockBase);
	assign inMap = blkIndex < usiPkg::blockId_t'(numChannels);

	// One-hot strobe for the addressed channel
	always_comb
	begin
		selNext = '0;
		for (int i = 0; i < numChannels; i++)
			selNext[i] = reqValid && inMap && (blkIndex == usiPkg::blockId_t'(i));
	end

	// ----------------------------------------
	// Request stage
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			sel <= '0;
			miss <= 1'b0;
		end
		else
		begin
			sel <= selNext;
			miss <= reqValid && !inMap;
		end
	end

	// Shared by every block, qualified by sel
	always_ff @(posedge sysClk)
	begin
		busWrite <= reqWrite;
		busOffset <= reqAddr[7:0];
		busData <= reqData;
	end

endmodule

`default_nettype wire

// ==== hw/axilUsiBridge.sv ====
// AXI4-Lite slave that turns each transfer into one internal bus transaction
`timescale 1ns/1ps
`default_nettype none

module axilUsiBridge (
	input wire logic sysClk,
	input wire logic rstN,
	// AXI4-Lite write address and data
	input wire logic awvalid,
	output logic awready,
	input wire usiPkg::usiAddr_t awaddr,
	input wire logic wvalid,
	output logic wready,
	input wire usiPkg::usiData_t wdata,
	input wire logic [$bits(usiPkg::usiData_t)/8-1:0] wstrb,
	// AXI4-Lite write response
	output logic bvalid,
	input wire logic bready,
	output usiPkg::axiResp_t bresp,
	// AXI4-Lite read address
	input wire logic arvalid,
	output logic arready,
	input wire usiPkg::usiAddr_t araddr,
	// AXI4-Lite read data
	output logic rvalid,
	input wire logic rready,
	output usiPkg::usiData_t rdata,
	output usiPkg::axiResp_t rresp,
	// Internal bus request
	output logic reqValid,
	output logic reqWrite,
	output usiPkg::usiAddr_t reqAddr,
	output usiPkg::usiData_t reqData,
	// Completion from the read collector
	input wire logic doneValid,
	input wire usiPkg::usiData_t doneData,
	input wire usiPkg::axiResp_t doneResp
);

	typedef enum logic [2:0] {
		idle,
		waitWrite,
		waitRead,
		respWrite,
		respRead
	} bridgeState_t;

	bridgeState_t state;
	logic wrAccept;
	logic rdAccept;
	// Completion kept until the master takes it
	usiPkg::usiData_t respData;
	usiPkg::axiResp_t respCode;

	// ----------------------------------------
	// Handshakes
	// ----------------------------------------
	// AW and W only together, and only from idle
	assign awready = (state == idle) && awvalid && wvalid;
	assign wready = (state == idle) && awvalid && wvalid;
	// Reads wait while any write beat is waiting, so writes win a tie
	assign arready = (state == idle) && arvalid && !awvalid && !wvalid;

	assign wrAccept = awvalid && awready;
	assign rdAccept = arvalid && arready;

	// Responses straight from the state
	assign bvalid = (state == respWrite);
	assign rvalid = (state == respRead);
	assign bresp = respCode;
	assign rresp = respCode;
	assign rdata = respData;

	// ----------------------------------------
	// Transfer FSM
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			state <= idle;
			reqValid <= 1'b0;
		end
		else
		begin
			// Request is a single-cycle pulse
			reqValid <= 1'b0;
			case (state)
				idle:
				begin
					if (wrAccept)
					begin
						state <= waitWrite;
						reqValid <= 1'b1;
					end
					else if (rdAccept)
					begin
						state <= waitRead;
						reqValid <= 1'b1;
					end
				end
				waitWrite:
					if (doneValid)
						state <= respWrite;
				waitRead:
					if (doneValid)
						state <= respRead;
				// Hold B until taken
				respWrite:
					if (bready)
						state <= idle;
				// Hold R until taken
				respRead:
					if (rready)
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	// Address and data latched at the handshake
	always_ff @(posedge sysClk)
	begin
		if (wrAccept)
		begin
			// Every write covers the whole word
			reqWrite <= 1'b1;
			reqAddr <= awaddr;
			reqData <= wdata;
		end
		else if (rdAccept)
		begin
			reqWrite <= 1'b0;
			reqAddr <= araddr;
		end
		// Capture the completion for the response phase
		if (doneValid)
		begin
			respData <= doneData;
			respCode <= doneResp;
		end
	end

endmodule

`default_nettype wire

// ==== hw/usiPkg.sv ====
// Internal bus typedefs, PWM block map base, register offsets and AXI response codes
`default_nettype none

package usiPkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	// Upper byte picks the block, lower byte the register
	typedef logic [15:0] usiAddr_t;
	// Data word on both the AXI side and the internal bus
	typedef logic [31:0] usiData_t;
	// Block field of an address
	typedef logic [7:0] blockId_t;
	// Register offset inside one block
	typedef logic [7:0] regOffset_t;
	// Period, duty and counter of one PWM channel
	typedef logic [15:0] pwmCount_t;

	// ----------------------------------------
	// Block map
	// ----------------------------------------
	// Channel 0 sits here, channel i at base plus i
	localparam blockId_t pwmBlockBase = 8'h02;

	// Register offsets of a PWM block
	localparam regOffset_t regCtrl = 8'h00;
	localparam regOffset_t regPeriod = 8'h04;
	localparam regOffset_t regDuty = 8'h08;
	// Free-running counter, read only
	localparam regOffset_t regCount = 8'h0C;

	// ----------------------------------------
	// AXI response codes
	// ----------------------------------------
	typedef logic [1:0] axiResp_t;
	localparam axiResp_t respOkay = 2'd0;
	// Block outside the map
	localparam axiResp_t respDecErr = 2'd3;

endpackage

`default_nettype wire
